// File: decim_cfg.svh
// ############################
// Build-time configuration for the decimator.
// MAX_N sets the width of every ratio and count.
// KEEP_FIRST is fixed at build time and not changeable at run time.
// ############################

`ifndef DECIM_CFG_SVH
`define DECIM_CFG_SVH

// Width of one data word in bits
`define DECIM_WIDTH 16

// Largest decimation ratio the counters can hold
`define DECIM_MAX_N 255

// Selects which beat or packet of each group survives
// 0 keeps the last of the group, 1 keeps the first
`define DECIM_KEEP_FIRST 0

`endif

// File: decim_counter.sv
// ############################
// Sample and packet counters that run from 1 to the active ratio.
// A ratio of zero forces every flag high, so nothing is dropped.
// A load makes the counts read as 1 in the same cycle.
// ############################

`timescale 1ns/1ps
`default_nettype none

module decim_counter
  import decim_types_pkg::*;
(
  input  wire logic   clk,
  input  wire logic   reset,
  input  wire logic   i_load,
  input  wire ratio_t i_active_n,
  input  wire logic   i_fire,
  input  wire logic   i_last,
  output logic        o_first_sample,
  output logic        o_last_sample,
  output logic        o_first_pkt,
  output logic        o_last_pkt
);

  ratio_t sample_cnt;
  ratio_t pkt_cnt;
  ratio_t sample_eff;
  ratio_t pkt_eff;
  logic   n_zero;

  // A beat taken during the load cycle is already the first one of the new group
  assign sample_eff = i_load ? ratio_t'(1) : sample_cnt;
  assign pkt_eff    = i_load ? ratio_t'(1) : pkt_cnt;
  assign n_zero     = (i_active_n == '0);

  assign o_first_sample = (sample_eff == ratio_t'(1)) | n_zero;
  assign o_last_sample  = (sample_eff >= i_active_n) | n_zero;
  assign o_first_pkt    = (pkt_eff == ratio_t'(1)) | n_zero;
  assign o_last_pkt     = (pkt_eff >= i_active_n) | n_zero;

  always_ff @(posedge clk) begin
    if (reset) begin
      sample_cnt <= ratio_t'(1);
    end else if (i_fire) begin
      sample_cnt <= o_last_sample ? ratio_t'(1) : sample_eff + ratio_t'(1);
    end else if (i_load) begin
      sample_cnt <= ratio_t'(1);
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      pkt_cnt <= ratio_t'(1);
    end else if (i_fire & i_last) begin
      // The packet count moves on the closing beat of each packet
      pkt_cnt <= o_last_pkt ? ratio_t'(1) : pkt_eff + ratio_t'(1);
    end else if (i_load) begin
      pkt_cnt <= ratio_t'(1);
    end
  end

  // Counts stay inside the ratio that the state machine hands over
  a_count_range: assert property (@(posedge clk) disable iff (reset)
    !i_load && !n_zero |-> sample_cnt <= i_active_n && pkt_cnt <= i_active_n);

endmodule

`default_nettype wire

// File: decim_ctrl_pkg.sv
// ############################
// Control types of the ratio state machine.
// ############################

`default_nettype none

package decim_ctrl_pkg;

  // LOAD takes the requested ratio and restarts the counts
  // RUN decimates with the active ratio
  // PENDING waits for the open packet to close before a reload
  typedef enum logic [1:0] {
    LOAD,
    RUN,
    PENDING
  } ratio_state_t;

endpackage

`default_nettype wire

// File: decim_gate.sv
// ############################
// Keep or drop decision per beat, purely combinational.
// Dropped beats are taken without waiting for the output side.
// ############################

`timescale 1ns/1ps
`default_nettype none

`include "decim_cfg.svh"

module decim_gate
  import decim_types_pkg::*;
(
  input  wire logic  i_vector_mode,
  input  wire logic  i_in_valid,
  input  wire beat_t i_in_beat,
  output logic       o_in_ready,
  output logic       o_fire,
  output logic       o_out_valid,
  output beat_t      o_out_beat,
  input  wire logic  i_out_ready,
  input  wire logic  i_first_sample,
  input  wire logic  i_last_sample,
  input  wire logic  i_first_pkt,
  input  wire logic  i_last_pkt
);

  logic keep_sample;
  logic keep_pkt;
  logic keep;

  assign keep_sample = (`DECIM_KEEP_FIRST != 0) ? i_first_sample : i_last_sample;
  assign keep_pkt    = (`DECIM_KEEP_FIRST != 0) ? i_first_pkt : i_last_pkt;
  assign keep        = i_vector_mode ? keep_pkt : keep_sample;

  assign o_in_ready  = keep ? i_out_ready : 1'b1;
  assign o_fire      = i_in_valid & o_in_ready;
  assign o_out_valid = i_in_valid & keep;

  // In sample mode a kept beat closes an output packet only once per N packets
  assign o_out_beat.data = i_in_beat.data;
  assign o_out_beat.last = i_in_beat.last & (i_vector_mode | i_last_pkt);

endmodule

`default_nettype wire

// File: decim_ratio_fsm.sv
// ############################
// Applies a requested ratio only between packets.
// During LOAD the requested ratio is already visible on o_active_n.
// A ratio change inside a packet waits for that packet's last beat.
// ############################

`timescale 1ns/1ps
`default_nettype none

module decim_ratio_fsm
  import decim_types_pkg::*;
  import decim_ctrl_pkg::*;
(
  input  wire logic   clk,
  input  wire logic   reset,
  input  wire ratio_t i_n,
  input  wire logic   i_fire,
  input  wire logic   i_last,
  output ratio_t      o_active_n,
  output logic        o_load
);

  ratio_state_t state;
  ratio_t       active_n_q;
  logic         pkt_open;
  logic         open_now;
  logic         n_differs;

  // A packet counts as open if one is already running or one starts right now
  assign open_now  = pkt_open | (i_fire & ~i_last);
  assign n_differs = (i_n != active_n_q);

  assign o_load = (state == LOAD);

  // In LOAD the new ratio is passed on at once, so beats in that cycle use it
  assign o_active_n = o_load ? i_n : active_n_q;

  always_ff @(posedge clk) begin
    if (reset) begin
      pkt_open <= 1'b0;
    end else if (i_fire) begin
      pkt_open <= ~i_last;
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      active_n_q <= '0;
    end else if (o_load) begin
      active_n_q <= i_n;
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      state <= LOAD;
    end else begin
      case (state)
        LOAD: begin
          state <= RUN;
        end
        RUN: begin
          if (n_differs) begin
            state <= open_now ? PENDING : LOAD;
          end
        end
        PENDING: begin
          // Reload in the cycle after the closing beat
          if (i_fire & i_last) begin
            state <= LOAD;
          end
        end
        default: begin
          state <= LOAD;
        end
      endcase
    end
  end

  // A reload happens only between packets and lasts a single cycle
  a_load_pulse: assert property (@(posedge clk) disable iff (reset)
    o_load |-> !pkt_open ##1 !o_load);

endmodule

`default_nettype wire

// File: decim_top.sv
// ############################
// Stream decimator, one in N beats or packets.
// Two cycles from input to output with no back-pressure.
// A new N takes effect only between packets.
// ############################

`timescale 1ns/1ps
`default_nettype none

module decim_top
  import decim_types_pkg::*;
(
  input  wire logic    clk,
  input  wire logic    reset,
  input  wire logic    i_vector_mode,
  input  wire ratio_t  i_n,
  input  wire logic    i_s_valid,
  input  wire sample_t i_s_data,
  input  wire logic    i_s_last,
  output logic         o_s_ready,
  output logic         o_m_valid,
  output sample_t      o_m_data,
  output logic         o_m_last,
  input  wire logic    i_m_ready
);

  beat_t  s_beat;
  beat_t  m_beat;
  beat_t  in_beat;
  beat_t  out_beat;
  logic   in_valid;
  logic   in_ready;
  logic   in_fire;
  logic   out_valid;
  logic   out_ready;
  ratio_t active_n;
  logic   load;
  logic   first_sample;
  logic   last_sample;
  logic   first_pkt;
  logic   last_pkt;

  assign s_beat.data = i_s_data;
  assign s_beat.last = i_s_last;
  assign o_m_data    = m_beat.data;
  assign o_m_last    = m_beat.last;

  stream_reg_slice #(.T(beat_t)) u_in_slice (
    .clk(clk), .reset(reset),
    .i_valid(i_s_valid), .i_data(s_beat), .o_ready(o_s_ready),
    .o_valid(in_valid), .o_data(in_beat), .i_ready(in_ready)
  );

  decim_ratio_fsm u_fsm (
    .clk(clk), .reset(reset), .i_n(i_n),
    .i_fire(in_fire), .i_last(in_beat.last),
    .o_active_n(active_n), .o_load(load)
  );

  decim_counter u_counter (
    .clk(clk), .reset(reset), .i_load(load), .i_active_n(active_n),
    .i_fire(in_fire), .i_last(in_beat.last),
    .o_first_sample(first_sample), .o_last_sample(last_sample),
    .o_first_pkt(first_pkt), .o_last_pkt(last_pkt)
  );

  decim_gate u_gate (
    .i_vector_mode(i_vector_mode),
    .i_in_valid(in_valid), .i_in_beat(in_beat), .o_in_ready(in_ready), .o_fire(in_fire),
    .o_out_valid(out_valid), .o_out_beat(out_beat), .i_out_ready(out_ready),
    .i_first_sample(first_sample), .i_last_sample(last_sample),
    .i_first_pkt(first_pkt), .i_last_pkt(last_pkt)
  );

  stream_reg_slice #(.T(beat_t)) u_out_slice (
    .clk(clk), .reset(reset),
    .i_valid(out_valid), .i_data(out_beat), .o_ready(out_ready),
    .o_valid(o_m_valid), .o_data(m_beat), .i_ready(i_m_ready)
  );

endmodule

`default_nettype wire

// File: decim_types_pkg.sv
// ############################
// Payload and count types of the decimator stream.
// Widths follow the build-time configuration header.
// ############################

`default_nettype none

`include "decim_cfg.svh"

package decim_types_pkg;

  // One data word of the stream
  typedef logic [`DECIM_WIDTH-1:0] sample_t;

  // Ratio and counter type, sized to hold MAX_N
  typedef logic [$clog2(`DECIM_MAX_N+1)-1:0] ratio_t;

  // One beat as carried through the register slices
  typedef struct packed {
    sample_t data;
    logic    last;
  } beat_t;

endpackage

`default_nettype wire

// File: sim.f
+incdir+.
decim_types_pkg.sv
decim_ctrl_pkg.sv
stream_reg_slice.sv
decim_ratio_fsm.sv
decim_counter.sv
decim_gate.sv
decim_top.sv
tb_decim_top.sv

// File: stream_reg_slice.sv
// ############################
// Registered valid/ready slice with a skid entry.
// One cycle of latency, full rate, registered ready.
// Payload type is set by parameter T.
// ############################

`timescale 1ns/1ps
`default_nettype none

module stream_reg_slice
  import decim_types_pkg::*;
#(
  parameter type T = beat_t
) (
  input  wire logic clk,
  input  wire logic reset,
  input  wire logic i_valid,
  input  wire T     i_data,
  output logic      o_ready,
  output logic      o_valid,
  output T          o_data,
  input  wire logic i_ready
);

  T     main_data;
  T     skid_data;
  logic main_valid;
  logic skid_valid;
  logic main_load;

  // The main entry can take new data when it is empty or being drained
  assign main_load = ~main_valid | i_ready;

  // Ready only depends on the skid entry, so it comes straight from a flop
  assign o_ready = ~skid_valid;
  assign o_valid = main_valid;
  assign o_data  = main_data;

  always_ff @(posedge clk) begin
    if (reset) begin
      main_valid <= 1'b0;
      skid_valid <= 1'b0;
    end else if (main_load) begin
      main_valid <= skid_valid | i_valid;
      skid_valid <= 1'b0;
    end else if (i_valid & ~skid_valid) begin
      // Main is stalled, so the beat accepted this cycle parks in the skid entry
      skid_valid <= 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (main_load) begin
      main_data <= skid_valid ? skid_data : i_data;
    end
    if (~main_load & i_valid & ~skid_valid) begin
      skid_data <= i_data;
    end
  end

  // A stalled output beat must not change until it is taken
  a_hold_stable: assert property (@(posedge clk) disable iff (reset)
    o_valid && !i_ready |=> o_valid && $stable(o_data));

endmodule

`default_nettype wire

// File: tb_decim_top.sv
// ##############################
// Testbench for the stream decimator.
// Kept beats are predicted by a queue model of the keep rules.
// The model reads KEEP_FIRST from the configuration header.
// ##############################

`timescale 1ns/1ps
`default_nettype none

`include "decim_cfg.svh"

module tb_decim_top
  import decim_types_pkg::*;
();

  localparam logic [31:0] SEED = 32'h19aef00a;

  logic    clk = 1'b0;
  logic    reset;
  logic    i_vector_mode;
  ratio_t  i_n;
  logic    i_s_valid;
  sample_t i_s_data;
  logic    i_s_last;
  logic    o_s_ready;
  logic    o_m_valid;
  sample_t o_m_data;
  logic    o_m_last;
  logic    i_m_ready;

  // Table columns, one entry per test row
  string row_name [$];
  int    row_n [$];
  int    row_vec [$];
  int    row_len [$];
  int    row_pkts [$];
  int    row_bp [$];
  int    row_n2 [$];
  int    row_chg_at [$];
  int    row_lat [$];
  int    row_kept_last [$];
  int    row_kept_first [$];

  sample_t     exp_data [$];
  logic        exp_last [$];
  int          in_time [$];
  int          m_n;
  int          m_scnt;
  int          m_pcnt;
  int          m_next_n;
  bit          m_vec;
  bit          m_pending;
  int          data_errs = 0;
  int          last_errs = 0;
  int          lat_errs = 0;
  int          other_errs = 0;
  int          cyc = 0;
  int          row_idx = 0;
  int          out_count = 0;
  int          bp_pct = 0;
  bit          lat_check = 1'b0;
  logic [31:0] data_rng = SEED;
  logic [31:0] bp_rng = SEED;

  decim_top dut (
    .clk(clk), .reset(reset), .i_vector_mode(i_vector_mode), .i_n(i_n),
    .i_s_valid(i_s_valid), .i_s_data(i_s_data), .i_s_last(i_s_last), .o_s_ready(o_s_ready),
    .o_m_valid(o_m_valid), .o_m_data(o_m_data), .o_m_last(o_m_last), .i_m_ready(i_m_ready)
  );

  always #4 clk = ~clk;

  always @(posedge clk) begin
    cyc <= cyc + 1;
  end

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  // Output ready is low for roughly bp_pct percent of the cycles
  always @(posedge clk) begin
    bp_rng = xorshift32(bp_rng);
    i_m_ready <= (bp_rng % 100) >= bp_pct;
  end

  task automatic add_row(input string name, input int n, input int vec, input int len,
                         input int pkts, input int bp, input int n2, input int chg_at,
                         input int lat, input int kept_last, input int kept_first);
    row_name.push_back(name);
    row_n.push_back(n);
    row_vec.push_back(vec);
    row_len.push_back(len);
    row_pkts.push_back(pkts);
    row_bp.push_back(bp);
    row_n2.push_back(n2);
    row_chg_at.push_back(chg_at);
    row_lat.push_back(lat);
    row_kept_last.push_back(kept_last);
    row_kept_first.push_back(kept_first);
  endtask

  task automatic set_ratio(input int n);
    m_n = n;
    m_scnt = 1;
    m_pcnt = 1;
    m_pending = 1'b0;
  endtask

  // Runs one input beat through the keep rules and queues what should come out
  task automatic model_beat(input sample_t data, input logic last, input bit chg);
    logic keep;
    logic out_last;
    if (m_n == 0) begin
      keep = 1'b1;
      out_last = last;
    end else if (m_vec) begin
      keep = (`DECIM_KEEP_FIRST != 0) ? (m_pcnt == 1) : (m_pcnt == m_n);
      out_last = last;
    end else begin
      keep = (`DECIM_KEEP_FIRST != 0) ? (m_scnt == 1) : (m_scnt == m_n);
      out_last = last && (m_pcnt == m_n);
    end
    if (keep) begin
      exp_data.push_back(data);
      exp_last.push_back(out_last);
    end
    if (m_n != 0) begin
      m_scnt = (m_scnt == m_n) ? 1 : m_scnt + 1;
      if (last) begin
        m_pcnt = (m_pcnt == m_n) ? 1 : m_pcnt + 1;
      end
    end
    if (chg) begin
      m_pending = 1'b1;
    end
    // A ratio raised inside a packet applies from the next packet on
    if (last && m_pending) begin
      set_ratio(m_next_n);
    end
  endtask

  task automatic send_beat(input logic last, input bit chg);
    sample_t data;
    bit      accepted;
    data_rng = xorshift32(data_rng);
    data = sample_t'(data_rng);
    model_beat(data, last, chg);
    i_s_valid <= 1'b1;
    i_s_data  <= data;
    i_s_last  <= last;
    accepted = 1'b0;
    while (!accepted) begin
      @(negedge clk);
      accepted = o_s_ready;
      if (accepted && lat_check) begin
        in_time.push_back(cyc);
      end
      @(posedge clk);
    end
  endtask

  task automatic send_row(input int r);
    int beat;
    bit last;
    int wait_cycles;
    i_vector_mode <= row_vec[r];
    i_n <= ratio_t'(row_n[r]);
    bp_pct <= row_bp[r];
    lat_check = row_lat[r];
    m_vec = row_vec[r];
    m_next_n = row_n2[r];
    if (row_n[r] != m_n) begin
      set_ratio(row_n[r]);
    end
    out_count = 0;
    repeat (3) @(posedge clk);
    for (beat = 0; beat < row_len[r] * row_pkts[r]; beat++) begin
      last = ((beat + 1) % row_len[r]) == 0;
      if (beat == row_chg_at[r]) begin
        i_n <= ratio_t'(row_n2[r]);
      end
      send_beat(last, beat == row_chg_at[r]);
    end
    i_s_valid <= 1'b0;
    // Kept beats may still sit behind back-pressure, give them a bounded time to leave
    wait_cycles = 0;
    while (exp_data.size() != 0 && wait_cycles < 100) begin
      @(posedge clk);
      wait_cycles++;
    end
    // Dropped tail beats leave the slices within two cycles of their transfer
    repeat (4) @(posedge clk);
  endtask

  always @(negedge clk) begin : monitor
    sample_t exp_d;
    logic    exp_l;
    int      t_in;
    if (!reset && o_m_valid && i_m_ready) begin
      out_count++;
      assert (exp_data.size() != 0) else begin
        other_errs++;
        $display("Error: %s put out a beat that was not expected", row_name[row_idx]);
      end
      if (exp_data.size() != 0) begin
        exp_d = exp_data.pop_front();
        exp_l = exp_last.pop_front();
        assert (o_m_data == exp_d) else begin
          data_errs++;
          $display("Error: %s data expected %h actual %h", row_name[row_idx], exp_d, o_m_data);
        end
        assert (o_m_last == exp_l) else begin
          last_errs++;
          $display("Error: %s last expected %0b actual %0b", row_name[row_idx], exp_l, o_m_last);
        end
      end
      if (lat_check && in_time.size() != 0) begin
        t_in = in_time.pop_front();
        assert (cyc - t_in == 2) else begin
          lat_errs++;
          $display("Error: %s latency expected 2 actual %0d", row_name[row_idx], cyc - t_in);
        end
      end
    end
  end

  initial begin : watchdog
    int total;
    int r;
    #1;
    total = 0;
    for (r = 0; r < row_name.size(); r++) begin
      total += row_len[r] * row_pkts[r];
    end
    repeat (total * 20) @(posedge clk);
    $display("Error: watchdog expired before all test rows had finished");
    $display("TEST FAILED");
    $finish;
  end

  initial begin : stimulus
    int r;
    int want;
    int errs;
    reset = 1'b1;
    i_vector_mode = 1'b0;
    i_n = '0;
    i_s_valid = 1'b0;
    i_s_data = '0;
    i_s_last = 1'b0;
    i_m_ready = 1'b1;
    set_ratio(0);
    // name, N, vector, length, packets, bp %, new N, change beat, latency, kept last/first
    add_row("sample_n3",       3, 0, 6, 4,  0, 0, -1, 0,  8,  8);
    add_row("vector_n2",       2, 1, 5, 4,  0, 0, -1, 0, 10, 10);
    add_row("sample_n0",       0, 0, 4, 3,  0, 0, -1, 0, 12, 12);
    add_row("vector_n0",       0, 1, 3, 3,  0, 0, -1, 0,  9,  9);
    add_row("backpressure_n4", 4, 0, 8, 5, 40, 0, -1, 0, 10, 10);
    add_row("change_n2_to_3",  2, 0, 5, 4,  0, 3,  2, 0,  7,  8);
    add_row("latency_n1",      1, 0, 4, 4,  0, 0, -1, 1, 16, 16);
    repeat (5) @(posedge clk);
    reset <= 1'b0;
    for (r = 0; r < row_name.size(); r++) begin
      row_idx = r;
      send_row(r);
      want = (`DECIM_KEEP_FIRST != 0) ? row_kept_first[r] : row_kept_last[r];
      assert (out_count == want) else begin
        other_errs++;
        $display("Error: %s kept beats expected %0d actual %0d", row_name[r], want, out_count);
      end
    end
    assert (exp_data.size() == 0) else begin
      other_errs++;
      $display("Error: %0d expected beats never came out", exp_data.size());
    end
    errs = data_errs + last_errs + lat_errs + other_errs;
    $display("Errors: %0d data, %0d last, %0d latency, %0d other",
             data_errs, last_errs, lat_errs, other_errs);
    if (errs == 0) begin
      $display("TEST OK");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire
